//--- design/tetris_pkg.sv
package tetris_pkg;

    // Palette index, 0 background, 1..7 pieces, 15 outline
    typedef logic [3:0] color_idx_t;

    // Red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    localparam color_idx_t COLOR_BG      = 4'd0;
    localparam color_idx_t COLOR_FIRST   = 4'd1;  // Colour of the first piece
    localparam color_idx_t COLOR_LAST    = 4'd7;  // Wraps back to COLOR_FIRST
    localparam color_idx_t COLOR_OUTLINE = 4'd15;

    // USB HID usage codes
    localparam logic [7:0] KEY_LEFT  = 8'h04;  // 'A'
    localparam logic [7:0] KEY_RIGHT = 8'h07;  // 'D'
    localparam logic [7:0] KEY_DOWN  = 8'h16;  // 'S'

    // Register byte addresses
    localparam logic [7:0] REG_KEY    = 8'h00;  // Write-only keycode
    localparam logic [7:0] REG_CTRL   = 8'h04;  // Bit 0 pause
    localparam logic [7:0] REG_STATUS = 8'h08;  // Row, column, locked count, game over

    // Index to RGB lookup
    localparam rgb_t PALETTE [16] = '{
        24'h000000,  // 0 background
        24'h00ffff,  // 1 cyan
        24'hffff00,  // 2 yellow
        24'h800080,  // 3 purple
        24'h00ff00,  // 4 green
        24'hff0000,  // 5 red
        24'h0000ff,  // 6 blue
        24'hffa500,  // 7 orange
        24'h202020,
        24'h303030,
        24'h404040,
        24'h505050,
        24'h606060,
        24'h707070,
        24'h808080,
        24'hffffff   // 15 outline
    };

endpackage

//--- design/apb_key_regs.sv
`timescale 1ns/1ps

module apb_key_regs import tetris_pkg::*; (
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    input  logic        cmd_taken,     // Field consumed the key this tick
    input  logic [4:0]  piece_row,
    input  logic [3:0]  piece_col,
    input  logic [7:0]  locked_count,
    input  logic        game_over,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [7:0]  cmd_key,
    output logic        cmd_pending,
    output logic        pause
);

    logic        access;       // Second APB cycle
    logic        addr_ok;      // Address is one of the three registers
    logic        key_wr;
    logic        ctrl_wr;
    logic [31:0] status_word;

    assign access  = psel && penable;
    assign addr_ok = (paddr == REG_KEY) || (paddr == REG_CTRL) || (paddr == REG_STATUS);
    assign key_wr  = access && pwrite && (paddr == REG_KEY);
    assign ctrl_wr = access && pwrite && (paddr == REG_CTRL);

    assign pready  = access;  // No wait states
    assign pslverr = access && (!addr_ok || (pwrite && (paddr == REG_STATUS)));

    // Status layout: game over | locked count | column | row
    assign status_word = {game_over, 7'd0, locked_count, 4'd0, piece_col, 3'd0, piece_row};

    // Read mux, only driven during a read access
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_CTRL:   prdata = {31'd0, pause};
                REG_STATUS: prdata = status_word;
                default:    prdata = '0;  // REG_KEY reads zero
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            cmd_pending <= 1'b0;
            pause       <= 1'b0;
        end else begin
            if (key_wr) begin
                cmd_pending <= 1'b1;  // New key wins over a same-cycle take
            end else if (cmd_taken) begin
                cmd_pending <= 1'b0;
            end
            if (ctrl_wr) begin
                pause <= pwdata[0];
            end
        end
    end

    // Latest keycode, overwritten by each write
    always_ff @(posedge Clk) begin
        if (key_wr) begin
            cmd_key <= pwdata[7:0];
        end
    end

    // A take without a fresh write must leave nothing pending
    a_take_clears: assert property (@(posedge Clk) disable iff (!rst_n)
        (cmd_taken && !key_wr) |=> !cmd_pending);

endmodule

//--- design/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 33
) (
    input  logic       Clk,
    input  logic       rst_n,
    output logic [9:0] draw_x,
    output logic [9:0] draw_y,
    output logic       hs,          // Active low
    output logic       vs,          // Active low
    output logic       blank_n,
    output logic       frame_tick   // First cycle of the first vsync line
);

    // Horizontal boundaries in pixels
    localparam logic [9:0] H_ACT_END  = 10'(H_ACTIVE);
    localparam logic [9:0] H_SYNC_BEG = 10'(H_ACTIVE + H_FP);
    localparam logic [9:0] H_SYNC_END = 10'(H_ACTIVE + H_FP + H_SYNC);
    localparam logic [9:0] H_LAST     = 10'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);

    // Vertical boundaries in lines
    localparam logic [9:0] V_ACT_END  = 10'(V_ACTIVE);
    localparam logic [9:0] V_SYNC_BEG = 10'(V_ACTIVE + V_FP);
    localparam logic [9:0] V_SYNC_END = 10'(V_ACTIVE + V_FP + V_SYNC);
    localparam logic [9:0] V_LAST     = 10'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       line_end;
    logic       h_sync_on;
    logic       v_sync_on;

    assign line_end = (h_cnt == H_LAST);

    // Pixel counter, one pixel per clock
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // Line counter steps at the end of each line
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            v_cnt <= '0;
        end else if (line_end) begin
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    assign h_sync_on = (h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END);
    assign v_sync_on = (v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END);

    assign draw_x     = h_cnt;
    assign draw_y     = v_cnt;
    assign hs         = !h_sync_on;
    assign vs         = !v_sync_on;
    assign blank_n    = (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);
    assign frame_tick = (v_cnt == V_SYNC_BEG) && (h_cnt == 10'd0);

    // Field logic relies on a single update per frame
    a_tick_single: assert property (@(posedge Clk) disable iff (!rst_n)
        frame_tick |=> !frame_tick);

endmodule

//--- design/block_field.sv
`timescale 1ns/1ps

module block_field import tetris_pkg::*; #(
    parameter int         COLS        = 10,
    parameter int         ROWS        = 20,
    parameter int         FALL_FRAMES = 30,
    parameter logic [1:0] CELL_SHIFT  = 2'd2   // log2 of cell size in pixels
) (
    input  logic       Clk,
    input  logic       rst_n,
    input  logic       frame_tick,
    input  logic [7:0] cmd_key,
    input  logic       cmd_pending,
    input  logic       pause,
    input  logic [9:0] draw_x,
    input  logic [9:0] draw_y,
    output logic       cmd_taken,
    output logic [4:0] piece_row,
    output logic [3:0] piece_col,
    output logic [7:0] locked_count,
    output logic       game_over,
    output color_idx_t cell_color,   // Same cycle as draw_x/draw_y
    output logic       cell_filled
);

    localparam logic [4:0] LAST_ROW  = 5'(ROWS - 1);
    localparam logic [3:0] LAST_COL  = 4'(COLS - 1);
    localparam logic [3:0] SPAWN_COL = 4'(COLS / 2);
    localparam logic [7:0] FALL_LAST = 8'(FALL_FRAMES - 1);

    color_idx_t grid [ROWS][COLS];  // Locked cells
    color_idx_t piece_color;
    color_idx_t next_color;
    logic [7:0] fall_cnt;           // Frames since last gravity step

    logic       active;
    logic [3:0] col_lf;
    logic [3:0] col_rt;
    logic [4:0] row_dn;
    logic       free_lf;
    logic       free_rt;
    logic       free_dn;
    logic [4:0] mv_row;             // Position after the command
    logic [3:0] mv_col;
    logic [4:0] mv_dn;
    logic       gravity;
    logic       land;
    logic       spawn_hit;
    logic [9:0] cell_x;
    logic [9:0] cell_y;
    logic       in_field;
    logic [4:0] look_row;
    logic [3:0] look_col;

    assign active    = frame_tick && !pause && !game_over;
    assign cmd_taken = frame_tick && cmd_pending;  // Key dropped when paused

    // Neighbour indices clamped inside the grid
    assign col_lf = (piece_col == 4'd0) ? piece_col : piece_col - 4'd1;
    assign col_rt = (piece_col == LAST_COL) ? piece_col : piece_col + 4'd1;
    assign row_dn = (piece_row == LAST_ROW) ? piece_row : piece_row + 5'd1;

    assign free_lf = (piece_col != 4'd0) && (grid[piece_row][col_lf] == COLOR_BG);
    assign free_rt = (piece_col != LAST_COL) && (grid[piece_row][col_rt] == COLOR_BG);
    assign free_dn = (piece_row != LAST_ROW) && (grid[row_dn][piece_col] == COLOR_BG);

    // Apply the pending key
    always_comb begin
        mv_row = piece_row;
        mv_col = piece_col;
        if (active && cmd_pending) begin
            case (cmd_key)
                KEY_LEFT: begin
                    if (free_lf) begin
                        mv_col = col_lf;
                    end
                end
                KEY_RIGHT: begin
                    if (free_rt) begin
                        mv_col = col_rt;
                    end
                end
                KEY_DOWN: begin
                    if (free_dn) begin
                        mv_row = row_dn;
                    end
                end
                default: ;  // Anything else is no move
            endcase
        end
    end

    // Gravity acts on the moved position
    assign gravity    = active && (fall_cnt == FALL_LAST);
    assign mv_dn      = (mv_row == LAST_ROW) ? mv_row : mv_row + 5'd1;
    assign land       = (mv_row == LAST_ROW) || (grid[mv_dn][mv_col] != COLOR_BG);
    assign next_color = (piece_color == COLOR_LAST) ? COLOR_FIRST : piece_color + 4'd1;

    // Spawn cell taken, either already or by the piece now locking
    assign spawn_hit = (grid[0][SPAWN_COL] != COLOR_BG) ||
                       ((mv_row == 5'd0) && (mv_col == SPAWN_COL));

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    grid[r][c] <= COLOR_BG;
                end
            end
            piece_row    <= '0;
            piece_col    <= SPAWN_COL;
            piece_color  <= COLOR_FIRST;
            fall_cnt     <= '0;
            locked_count <= '0;
            game_over    <= 1'b0;
        end else if (active) begin
            piece_row <= mv_row;
            piece_col <= mv_col;
            if (gravity) begin
                fall_cnt <= '0;
                if (land) begin
                    grid[mv_row][mv_col] <= piece_color;  // Lock in place
                    locked_count         <= locked_count + 8'd1;
                    piece_row            <= '0;
                    piece_col            <= SPAWN_COL;
                    piece_color          <= next_color;
                    game_over            <= spawn_hit;
                end else begin
                    piece_row <= mv_dn;
                end
            end else begin
                fall_cnt <= fall_cnt + 8'd1;
            end
        end
    end

    // Pixel to cell lookup
    assign cell_x   = draw_x >> CELL_SHIFT;
    assign cell_y   = draw_y >> CELL_SHIFT;
    assign in_field = (cell_x < 10'(COLS)) && (cell_y < 10'(ROWS));
    assign look_row = in_field ? cell_y[4:0] : 5'd0;  // Keeps index in range
    assign look_col = in_field ? cell_x[3:0] : 4'd0;

    always_comb begin
        if (!in_field) begin
            cell_color = COLOR_BG;
        end else if ((look_row == piece_row) && (look_col == piece_col)) begin
            cell_color = piece_color;  // Falling piece drawn over the grid
        end else begin
            cell_color = grid[look_row][look_col];
        end
    end

    assign cell_filled = (cell_color != COLOR_BG);

    a_col_range: assert property (@(posedge Clk) disable iff (!rst_n)
        int'(piece_col) < COLS);

endmodule

//--- design/pixel_shader.sv
`timescale 1ns/1ps

module pixel_shader import tetris_pkg::*; #(
    parameter logic [1:0] CELL_SHIFT = 2'd2
) (
    input  logic       Clk,
    input  logic       rst_n,
    input  logic [9:0] draw_x,
    input  logic [9:0] draw_y,
    input  color_idx_t cell_color,
    input  logic       cell_filled,
    input  logic       hs,
    input  logic       vs,
    input  logic       blank_n,
    output rgb_t       rgb,
    output logic       hs_out,
    output logic       vs_out,
    output logic       blank_out_n
);

    // Low coordinate bits inside one cell
    localparam logic [9:0] CELL_MASK = (10'd1 << CELL_SHIFT) - 10'd1;

    logic       on_edge;
    color_idx_t shade_idx;
    rgb_t       rgb_next;

    // Top and left pixel of each cell form the outline
    assign on_edge   = ((draw_x & CELL_MASK) == 10'd0) || ((draw_y & CELL_MASK) == 10'd0);
    assign shade_idx = (cell_filled && on_edge) ? COLOR_OUTLINE : cell_color;
    assign rgb_next  = blank_n ? PALETTE[shade_idx] : '0;  // Black outside active area

    // One stage, colour and syncs kept aligned
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            rgb         <= '0;
            hs_out      <= 1'b1;
            vs_out      <= 1'b1;
            blank_out_n <= 1'b0;
        end else begin
            rgb         <= rgb_next;
            hs_out      <= hs;
            vs_out      <= vs;
            blank_out_n <= blank_n;
        end
    end

endmodule

//--- design/tetris_display_top.sv
`timescale 1ns/1ps

module tetris_display_top import tetris_pkg::*; #(
    parameter int         H_ACTIVE    = 640,
    parameter int         H_FP        = 16,
    parameter int         H_SYNC      = 96,
    parameter int         H_BP        = 48,
    parameter int         V_ACTIVE    = 480,
    parameter int         V_FP        = 10,
    parameter int         V_SYNC      = 2,
    parameter int         V_BP        = 33,
    parameter int         COLS        = 10,
    parameter int         ROWS        = 20,
    parameter int         FALL_FRAMES = 30,
    parameter logic [1:0] CELL_SHIFT  = 2'd3   // 8x8 pixel cells
) (
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output rgb_t        rgb,
    output logic        hs_out,
    output logic        vs_out,
    output logic        blank_out_n
);

    // Register block to field
    logic [7:0] cmd_key;
    logic       cmd_pending;
    logic       cmd_taken;
    logic       pause;
    logic [4:0] piece_row;
    logic [3:0] piece_col;
    logic [7:0] locked_count;
    logic       game_over;

    // Raster
    logic [9:0] draw_x;
    logic [9:0] draw_y;
    logic       hs;
    logic       vs;
    logic       blank_n;
    logic       frame_tick;
    color_idx_t cell_color;
    logic       cell_filled;

    apb_key_regs regs_i (
        .Clk(Clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .cmd_taken(cmd_taken),
        .piece_row(piece_row), .piece_col(piece_col),
        .locked_count(locked_count), .game_over(game_over),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cmd_key(cmd_key), .cmd_pending(cmd_pending), .pause(pause)
    );

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timing_i (
        .Clk(Clk), .rst_n(rst_n),
        .draw_x(draw_x), .draw_y(draw_y),
        .hs(hs), .vs(vs), .blank_n(blank_n), .frame_tick(frame_tick)
    );

    block_field #(
        .COLS(COLS), .ROWS(ROWS), .FALL_FRAMES(FALL_FRAMES), .CELL_SHIFT(CELL_SHIFT)
    ) field_i (
        .Clk(Clk), .rst_n(rst_n),
        .frame_tick(frame_tick),
        .cmd_key(cmd_key), .cmd_pending(cmd_pending), .pause(pause),
        .draw_x(draw_x), .draw_y(draw_y),
        .cmd_taken(cmd_taken),
        .piece_row(piece_row), .piece_col(piece_col),
        .locked_count(locked_count), .game_over(game_over),
        .cell_color(cell_color), .cell_filled(cell_filled)
    );

    pixel_shader #(
        .CELL_SHIFT(CELL_SHIFT)
    ) shader_i (
        .Clk(Clk), .rst_n(rst_n),
        .draw_x(draw_x), .draw_y(draw_y),
        .cell_color(cell_color), .cell_filled(cell_filled),
        .hs(hs), .vs(vs), .blank_n(blank_n),
        .rgb(rgb), .hs_out(hs_out), .vs_out(vs_out), .blank_out_n(blank_out_n)
    );

endmodule

//--- tests/tb_tetris_display.sv
`timescale 1ns/1ps

module tb_tetris_display import tetris_pkg::*; ();

    // Small raster so a full drop fits in a short run
    localparam int H_ACTIVE = 48;
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BP     = 2;
    localparam int V_ACTIVE = 84;
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 1;
    localparam int COLS        = 10;
    localparam int ROWS        = 20;
    localparam int FALL_FRAMES = 2;
    localparam logic [1:0] CELL_SHIFT = 2'd2;
    localparam int CELL_PX        = 1 << CELL_SHIFT;
    localparam int H_TOTAL        = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 56
    localparam int V_TOTAL        = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 88
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;                 // 4928
    localparam int TIMEOUT_CYCLES = 70 * FRAME_CYCLES;  // 40-frame drop plus moves and pause

    logic        Clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    rgb_t        rgb;
    logic        hs_out;
    logic        vs_out;
    logic        blank_out_n;

    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_cnt    = 0;
    string       test_name;
    logic        rd_check;          // Compare read data in this access
    logic [31:0] rd_exp;
    logic        probe_en;
    int          probe_x;
    int          probe_y;
    rgb_t        probe_rgb;
    int          ox;                // Raster position shown on the outputs
    int          oy;
    logic        vs_prev;
    int          frame_cnt;

    // Reference state of the field, stepped once per frame
    int          exp_row;
    int          exp_col;
    int          exp_locked;
    int          exp_color;
    logic        exp_over;
    int          exp_grid [ROWS][COLS];
    int          fall_phase;
    int          lock_row;
    int          lock_col;
    logic        key_waiting;
    logic [7:0]  key_code;
    logic        pause_on;

    tetris_display_top #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .COLS(COLS), .ROWS(ROWS), .FALL_FRAMES(FALL_FRAMES), .CELL_SHIFT(CELL_SHIFT)
    ) dut_i (
        .Clk(Clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .rgb(rgb), .hs_out(hs_out), .vs_out(vs_out), .blank_out_n(blank_out_n)
    );

    always #10 Clk = ~Clk;  // 20 ns period

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Only the three listed registers exist, status is read-only
    function automatic logic slverr_expected(input logic [7:0] addr, input logic wr);
        if (addr != REG_KEY && addr != REG_CTRL && addr != REG_STATUS) begin
            return 1'b1;
        end
        return wr && (addr == REG_STATUS);
    endfunction

    function automatic logic hsync_level(input int x);
        return !(x >= H_ACTIVE + H_FP && x < H_ACTIVE + H_FP + H_SYNC);
    endfunction

    function automatic logic vsync_level(input int y);
        return !(y >= V_ACTIVE + V_FP && y < V_ACTIVE + V_FP + V_SYNC);
    endfunction

    function automatic logic active_area(input int x, input int y);
        return (x < H_ACTIVE) && (y < V_ACTIVE);
    endfunction

    // Move, gravity, lock and spawn for one frame
    task automatic model_tick();
        if (!pause_on && !exp_over) begin
            if (key_waiting) begin
                case (key_code)
                    KEY_LEFT: begin
                        if (exp_col > 0 && exp_grid[exp_row][exp_col - 1] == 0) exp_col--;
                    end
                    KEY_RIGHT: begin
                        if (exp_col < COLS - 1 && exp_grid[exp_row][exp_col + 1] == 0) exp_col++;
                    end
                    KEY_DOWN: begin
                        if (exp_row < ROWS - 1 && exp_grid[exp_row + 1][exp_col] == 0) exp_row++;
                    end
                    default: ;
                endcase
            end
            if (fall_phase == FALL_FRAMES - 1) begin
                fall_phase = 0;
                if (exp_row == ROWS - 1 || exp_grid[exp_row + 1][exp_col] != 0) begin
                    exp_grid[exp_row][exp_col] = exp_color;
                    lock_row = exp_row;
                    lock_col = exp_col;
                    exp_locked++;
                    exp_row   = 0;
                    exp_col   = COLS / 2;
                    exp_color = (exp_color == 7) ? 1 : exp_color + 1;
                    exp_over  = (exp_grid[0][COLS / 2] != 0);
                end else begin
                    exp_row++;
                end
            end else begin
                fall_phase++;
            end
        end
        key_waiting = 1'b0;  // Taken on every tick, paused or not
    endtask

    // Output raster position, one cycle behind the DUT counters
    always @(posedge Clk) begin
        if (!rst_n) begin
            ox <= H_TOTAL - 1;
            oy <= V_TOTAL - 1;
        end else if (ox == H_TOTAL - 1) begin
            ox <= 0;
            oy <= (oy == V_TOTAL - 1) ? 0 : oy + 1;
        end else begin
            ox <= ox + 1;
        end
    end

    // Falling vs_out marks each frame tick
    always @(posedge Clk) begin
        vs_prev <= vs_out;
        if (!rst_n) begin
            frame_cnt   = 0;
            exp_row     = 0;
            exp_col     = COLS / 2;
            exp_locked  = 0;
            exp_color   = 1;
            exp_over    = 1'b0;
            fall_phase  = 0;
            key_waiting = 1'b0;
            pause_on    = 1'b0;
            foreach (exp_grid[r, c]) exp_grid[r][c] = 0;
        end else if (vs_prev && !vs_out) begin
            frame_cnt++;
            model_tick();
        end
    end

    always @(posedge Clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    a_pready: assert property (@(posedge Clk) disable iff (!rst_n)
        (psel && penable) |-> pready)
        else begin
            other_errors++;
            $display("pready was low in an access phase (%s)", test_name);
        end

    a_slverr: assert property (@(posedge Clk) disable iff (!rst_n)
        (psel && penable) |-> (pslverr == slverr_expected(paddr, pwrite)))
        else begin
            value_errors++;
            $display("FAIL %s: expected pslverr %b, actual %b", test_name,
                     slverr_expected($sampled(paddr), $sampled(pwrite)), $sampled(pslverr));
        end

    a_slverr_idle: assert property (@(posedge Clk) disable iff (!rst_n)
        !(psel && penable) |-> !pslverr)
        else begin
            other_errors++;
            $display("pslverr was high outside an access phase");
        end

    a_rdata: assert property (@(posedge Clk) disable iff (!rst_n)
        (psel && penable && !pwrite && rd_check) |-> (prdata == rd_exp))
        else begin
            value_errors++;
            $display("FAIL %s: expected %08h, actual %08h", test_name,
                     $sampled(rd_exp), $sampled(prdata));
        end

    // Reset values show up from the first edge with rst_n low
    a_reset_vals: assert property (@(posedge Clk)
        !rst_n |=> (hs_out && vs_out && !blank_out_n && rgb == '0 && !pslverr && !pready))
        else begin
            other_errors++;
            $display("Outputs left their reset values while rst_n was low");
        end

    a_hsync: assert property (@(posedge Clk) disable iff (!rst_n)
        hs_out == hsync_level(ox))
        else begin
            value_errors++;
            $display("FAIL hsync at x=%0d: expected %b, actual %b",
                     $sampled(ox), hsync_level($sampled(ox)), $sampled(hs_out));
        end

    a_vsync: assert property (@(posedge Clk) disable iff (!rst_n)
        vs_out == vsync_level(oy))
        else begin
            value_errors++;
            $display("FAIL vsync at y=%0d: expected %b, actual %b",
                     $sampled(oy), vsync_level($sampled(oy)), $sampled(vs_out));
        end

    a_blank: assert property (@(posedge Clk) disable iff (!rst_n)
        blank_out_n == active_area(ox, oy))
        else begin
            value_errors++;
            $display("FAIL blank at (%0d,%0d): expected %b, actual %b", $sampled(ox),
                     $sampled(oy), active_area($sampled(ox), $sampled(oy)), $sampled(blank_out_n));
        end

    a_black: assert property (@(posedge Clk) disable iff (!rst_n)
        !blank_out_n |-> (rgb == '0))
        else begin
            value_errors++;
            $display("FAIL blanked rgb: expected 000000, actual %06h", $sampled(rgb));
        end

    a_probe: assert property (@(posedge Clk) disable iff (!rst_n)
        (probe_en && ox == probe_x && oy == probe_y) |-> (rgb == probe_rgb))
        else begin
            value_errors++;
            $display("FAIL %s: expected %06h, actual %06h", test_name,
                     $sampled(probe_rgb), $sampled(rgb));
        end

    // Setup, access, then one idle cycle; starts right after a rising edge
    task automatic apb_write(input string name, input logic [7:0] addr, input logic [31:0] data);
        test_name = name;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge Clk);
        penable <= 1'b1;
        @(posedge Clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        if (addr == REG_KEY) begin
            key_code    = data[7:0];  // Newest key wins
            key_waiting = 1'b1;
        end
        if (addr == REG_CTRL) pause_on = data[0];
        @(posedge Clk);
    endtask

    task automatic apb_read(input string name, input logic [7:0] addr, input logic check,
                            input logic [31:0] exp);
        test_name = name;
        psel     <= 1'b1;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        paddr    <= addr;
        rd_check <= check;
        rd_exp   <= exp;
        @(posedge Clk);
        penable <= 1'b1;
        @(posedge Clk);
        psel     <= 1'b0;
        penable  <= 1'b0;
        rd_check <= 1'b0;
        @(posedge Clk);
    endtask

    task automatic check_status(input string name);
        logic [31:0] exp;
        exp = 32'(exp_row) | (32'(exp_col) << 8) | (32'(exp_locked) << 16) |
              (32'(exp_over) << 31);
        apb_read(name, REG_STATUS, 1'b1, exp);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target) @(negedge Clk);  // Model settled by the falling edge
        @(posedge Clk);
    endtask

    // Arms the pixel check and waits for that pixel on the outputs
    task automatic probe_pixel(input string name, input int x, input int y, input int idx);
        test_name = name;
        probe_x   <= x;
        probe_y   <= y;
        probe_rgb <= PALETTE[idx];
        probe_en  <= 1'b1;
        @(posedge Clk);
        while (!(ox == x && oy == y)) @(posedge Clk);
        probe_en <= 1'b0;
        @(posedge Clk);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [7:0]  key;
        Clk      = 1'b0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rd_check = 1'b0;
        rd_exp   = '0;
        probe_en = 1'b0;
        rnd      = 32'heb64_6e78;
        repeat (16) @(posedge Clk);
        rst_n <= 1'b1;
        @(posedge Clk);

        // Register port, all before the first frame tick
        check_status("reset status");  // Row 0, column 5
        apb_write("ctrl write", REG_CTRL, 32'h1);
        apb_read("ctrl readback", REG_CTRL, 1'b1, 32'h1);
        apb_write("ctrl write", REG_CTRL, 32'hffff_fffe);
        apb_read("ctrl readback", REG_CTRL, 1'b1, 32'h0);
        apb_write("bad address write", 8'h0c, 32'h5a);
        apb_read("bad address read", 8'h0c, 1'b0, 32'h0);
        apb_write("status write", REG_STATUS, 32'h0);
        apb_read("key read", REG_KEY, 1'b0, 32'h0);

        // Moves, one key per frame
        apb_write("key left", REG_KEY, {24'd0, KEY_LEFT});
        wait_frames(1);
        check_status("key left");
        repeat (2) begin
            apb_write("key right", REG_KEY, {24'd0, KEY_RIGHT});
            wait_frames(1);
        end
        check_status("key right");
        repeat (7) begin  // Six to the wall, the last one ignored
            apb_write("left wall", REG_KEY, {24'd0, KEY_LEFT});
            wait_frames(1);
        end
        check_status("left wall");
        for (int i = 0; i < 4; i++) begin
            rnd = next_random(rnd);
            key = rnd[23:16];
            if (key == KEY_LEFT || key == KEY_RIGHT || key == KEY_DOWN) key = key ^ 8'h80;
            apb_write("random key", REG_KEY, {24'd0, key});
            wait_frames(1);
            check_status("random key");
        end

        // Gravity down to the bottom and the lock
        while (exp_locked == 0) begin
            wait_frames(1);
            check_status("gravity");
        end

        // Pixels in raster order, all within one frame
        probe_pixel("background pixel", 1, 41, 0);
        probe_pixel("outside pixel", 45, 41, 0);
        probe_pixel("outline pixel", lock_col * CELL_PX, lock_row * CELL_PX, 15);
        probe_pixel("locked pixel", lock_col * CELL_PX + 1, lock_row * CELL_PX + 1,
                    exp_grid[lock_row][lock_col]);

        apb_write("pause on", REG_CTRL, 32'h1);
        repeat (6) begin
            wait_frames(1);
            check_status("pause hold");
        end
        apb_write("pause off", REG_CTRL, 32'h0);
        repeat (3) begin
            wait_frames(1);
            check_status("pause release");
        end

        repeat (4) @(posedge Clk);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- all.f
design/tetris_pkg.sv
design/apb_key_regs.sv
design/vga_timing.sv
design/block_field.sv
design/pixel_shader.sv
design/tetris_display_top.sv
tests/tb_tetris_display.sv

//--- Makefile
# Verilator build and run of the tetris display testbench

VERILATOR ?= verilator
TOP       ?= tb_tetris_display
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
